// File: hw/mem_stage_pkg.sv
package mem_stage_pkg;

    // Load size, as carried by the execute bundle.
    typedef enum logic [1:0] {
        LOAD_NONE,
        LOAD_BYTE,
        LOAD_WORD,
        LOAD_DOUBLE
    } load_kind_e;

    // Store size. Same encoding as the load sizes.
    typedef enum logic [1:0] {
        STORE_NONE,
        STORE_BYTE,
        STORE_WORD,
        STORE_DOUBLE
    } store_kind_e;

    // Execute to memory bundle.
    typedef struct packed {
        logic [63:0] alu_out;        // Address for loads and stores.
        logic [63:0] b_data;         // Store data, MTC0 source.
        logic [4:0]  w_regnum;
        logic [2:0]  sel;
        load_kind_e  mem_load_type;
        store_kind_e mem_store_type;
        logic        load_signed;
        logic        mfc0;
        logic        mtc0;
        logic        eret;
        logic        linkpc;
        logic [63:0] pc4;
        logic        overflow;
        logic        reserved_inst;
        logic        write_enable;
    } ex_regs_t;

    // Memory to writeback bundle.
    typedef struct packed {
        logic [63:0] epc;
        logic [63:0] w_data;
        logic [4:0]  w_regnum;
        logic        write_enable;
        logic        taken_handler;
    } mem_regs_t;

    // Data memory depth in doublewords.
    localparam int MEM_DWORDS  = 256;
    localparam int MEM_INDEX_W = $clog2(MEM_DWORDS);

    // CP0 register numbers, all at sel 0.
    localparam logic [4:0] CP0_STATUS = 5'd12;
    localparam logic [4:0] CP0_CAUSE  = 5'd13;
    localparam logic [4:0] CP0_EPC    = 5'd14;

    // Exception codes written into cause.
    localparam logic [4:0] EXC_INT = 5'd0;
    localparam logic [4:0] EXC_RI  = 5'd10;
    localparam logic [4:0] EXC_OV  = 5'd12;

endpackage

// File: hw/data_mem.sv
`timescale 1ns/10ps

module data_mem (
    input  logic                      clock,
    input  logic                      reset,
    input  logic [63:0]               addr,
    input  logic [63:0]               wdata,
    input  mem_stage_pkg::store_kind_e store_type,
    output logic [63:0]               rdata,
    input  logic [63:0]               inst_addr,
    output logic [31:0]               inst
);
    import mem_stage_pkg::*;

    logic [63:0] mem [MEM_DWORDS];
    logic [MEM_INDEX_W-1:0] d_index;
    logic [MEM_INDEX_W-1:0] i_index;
    logic [7:0]  byte_en;
    logic [63:0] lane_data;
    logic [63:0] inst_dword;

    // Upper address bits are ignored, the array wraps.
    assign d_index = addr[MEM_INDEX_W+2:3];
    assign i_index = inst_addr[MEM_INDEX_W+2:3];

    // Byte enables and lane-replicated write data.
    always_comb begin
        byte_en   = 8'h00;
        lane_data = wdata;
        case (store_type)
            STORE_BYTE: begin
                byte_en   = 8'h01 << addr[2:0];
                lane_data = {8{wdata[7:0]}};
            end
            STORE_WORD: begin
                byte_en   = addr[2] ? 8'hf0 : 8'h0f;
                lane_data = {2{wdata[31:0]}};
            end
            STORE_DOUBLE: begin
                byte_en = 8'hff;
            end
            default: byte_en = 8'h00;
        endcase
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            mem <= '{default: '0};
        end else begin
            for (int i = 0; i < 8; i++) begin
                if (byte_en[i]) begin
                    mem[d_index][i*8 +: 8] <= lane_data[i*8 +: 8];
                end
            end
        end
    end

    // Both read ports see the array before this cycle's store.
    assign rdata      = mem[d_index];
    assign inst_dword = mem[i_index];
    assign inst       = inst_addr[2] ? inst_dword[63:32] : inst_dword[31:0];

    a_store_type_known: assert property (
        @(posedge clock) disable iff (reset)
        !$isunknown(store_type)
    ) else $error("data_mem: store_type has unknown bits");

endmodule

// File: hw/load_align.sv
`timescale 1ns/10ps

module load_align (
    input  logic [63:0]              rdata,
    input  logic [2:0]               offset,
    input  mem_stage_pkg::load_kind_e load_type,
    input  logic                     load_signed,
    output logic [63:0]              load_data
);
    import mem_stage_pkg::*;

    logic [7:0]  byte_val;
    logic [31:0] word_val;

    assign byte_val = rdata[offset*8 +: 8];                  // Lane by bits 2:0.
    assign word_val = offset[2] ? rdata[63:32] : rdata[31:0];

    always_comb begin
        case (load_type)
            LOAD_BYTE: begin
                if (load_signed) begin
                    load_data = {{56{byte_val[7]}}, byte_val};
                end else begin
                    load_data = {56'b0, byte_val};
                end
            end
            LOAD_WORD: begin
                if (load_signed) begin
                    load_data = {{32{word_val[31]}}, word_val};
                end else begin
                    load_data = {32'b0, word_val};
                end
            end
            LOAD_DOUBLE: load_data = rdata;
            default:     load_data = '0;                    // Not a load, top uses ALU value.
        endcase
    end

endmodule

// File: hw/cp0_unit.sv
`timescale 1ns/10ps

module cp0_unit (
    input  logic        clock,
    input  logic        reset,
    input  logic [63:0] wr_data,
    input  logic [4:0]  regnum,
    input  logic [2:0]  sel,
    input  logic [63:0] next_pc,
    input  logic        mtc0,
    input  logic        eret,
    input  logic [7:0]  interrupt_sources,
    input  logic        overflow,
    input  logic        reserved_inst,
    output logic [63:0] rd_data,
    output logic [63:0] epc,
    output logic        taken_handler
);
    import mem_stage_pkg::*;

    logic [7:0]  int_mask;       // Status 15:8.
    logic        exl;            // Status 1.
    logic        ie;             // Status 0.
    logic [4:0]  exc_code;       // Cause 6:2.
    logic [63:0] epc_reg;
    logic [7:0]  pending;
    logic        sel_zero;
    logic        status_wr;
    logic        epc_wr;
    logic [4:0]  exc_next;

    assign pending   = interrupt_sources & int_mask;
    assign sel_zero  = (sel == 3'd0);
    assign status_wr = mtc0 && sel_zero && (regnum == CP0_STATUS);
    assign epc_wr    = mtc0 && sel_zero && (regnum == CP0_EPC);

    // Interrupts only while enabled and not already in a handler.
    assign taken_handler = overflow || reserved_inst || ((|pending) && ie && !exl);

    // Overflow beats reserved instruction, which beats interrupt.
    always_comb begin
        if (overflow) begin
            exc_next = EXC_OV;
        end else if (reserved_inst) begin
            exc_next = EXC_RI;
        end else begin
            exc_next = EXC_INT;
        end
    end

    // MFC0 read, unknown registers give zero.
    always_comb begin
        rd_data = '0;
        if (sel_zero) begin
            case (regnum)
                CP0_STATUS: rd_data = {48'b0, int_mask, 6'b0, exl, ie};
                CP0_CAUSE:  rd_data = {48'b0, interrupt_sources, 1'b0, exc_code, 2'b0};
                CP0_EPC:    rd_data = epc_reg;
                default:    rd_data = '0;
            endcase
        end
    end

    // EPC as it will stand after the coming edge.
    always_comb begin
        epc = epc_reg;
        if (taken_handler) begin
            epc = next_pc;
        end else if (epc_wr) begin
            epc = wr_data;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            int_mask <= '0;
            exl      <= 1'b0;
            ie       <= 1'b0;
            exc_code <= '0;
            epc_reg  <= '0;
        end else begin
            epc_reg <= epc;
            if (taken_handler) begin
                exl      <= 1'b1;
                exc_code <= exc_next;
            end else if (status_wr) begin
                int_mask <= wr_data[15:8];  // Other status bits are dropped.
                exl      <= wr_data[1];
                ie       <= wr_data[0];
            end else if (eret) begin
                exl <= 1'b0;
            end
        end
    end

    a_mtc0_eret_excl: assert property (
        @(posedge clock) disable iff (reset)
        !(mtc0 && eret)
    ) else $error("cp0_unit: mtc0 and eret in the same bundle");

endmodule

// File: hw/mem_stage.sv
`timescale 1ns/10ps

module mem_stage (
    input  logic                    clock,
    input  logic                    reset,
    input  mem_stage_pkg::ex_regs_t ex_regs,
    input  logic [63:0]             inst_addr,
    output logic [31:0]             inst,
    input  logic [7:0]              interrupt_sources,
    input  logic [63:0]             next_pc,
    input  logic                    d_valid,
    input  logic                    d_ready,
    input  logic [63:0]             d_rdata,
    output mem_stage_pkg::mem_regs_t mem_regs
);
    import mem_stage_pkg::*;

    logic        ext_active;
    store_kind_e store_type;
    logic [63:0] mem_rdata;
    logic [63:0] load_data;
    logic [63:0] cp0_rd_data;
    logic [63:0] epc;
    logic        taken_handler;
    logic [63:0] w_data;
    mem_regs_t   mem_next;

    // External port owns this cycle, so no store goes to memory.
    assign ext_active = d_valid || d_ready;
    assign store_type = ext_active ? STORE_NONE : ex_regs.mem_store_type;

    data_mem mem (
        .clock      (clock),
        .reset      (reset),
        .addr       (ex_regs.alu_out),
        .wdata      (ex_regs.b_data),
        .store_type (store_type),
        .rdata      (mem_rdata),
        .inst_addr  (inst_addr),
        .inst       (inst)
    );

    load_align align (
        .rdata       (mem_rdata),
        .offset      (ex_regs.alu_out[2:0]),
        .load_type   (ex_regs.mem_load_type),
        .load_signed (ex_regs.load_signed),
        .load_data   (load_data)
    );

    cp0_unit cp0 (
        .clock             (clock),
        .reset             (reset),
        .wr_data           (ex_regs.b_data),
        .regnum            (ex_regs.w_regnum),
        .sel               (ex_regs.sel),
        .next_pc           (next_pc),
        .mtc0              (ex_regs.mtc0),
        .eret              (ex_regs.eret),
        .interrupt_sources (interrupt_sources),
        .overflow          (ex_regs.overflow),
        .reserved_inst     (ex_regs.reserved_inst),
        .rd_data           (cp0_rd_data),
        .epc               (epc),
        .taken_handler     (taken_handler)
    );

    // Link PC first, then MFC0, then external data, then load or ALU.
    always_comb begin
        if (ex_regs.linkpc) begin
            w_data = ex_regs.pc4;
        end else if (ex_regs.mfc0) begin
            w_data = cp0_rd_data;
        end else if (ext_active) begin
            w_data = d_rdata;
        end else if (ex_regs.mem_load_type != LOAD_NONE) begin
            w_data = load_data;
        end else begin
            w_data = ex_regs.alu_out;
        end
    end

    assign mem_next.epc           = epc;
    assign mem_next.w_data        = w_data;
    assign mem_next.w_regnum      = ex_regs.w_regnum;
    assign mem_next.write_enable  = ex_regs.write_enable;
    assign mem_next.taken_handler = taken_handler;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            mem_regs <= '0;
        end else begin
            mem_regs <= mem_next;
        end
    end

    a_no_load_and_store: assert property (
        @(posedge clock) disable iff (reset)
        !(ex_regs.mem_load_type != LOAD_NONE && ex_regs.mem_store_type != STORE_NONE)
    ) else $error("mem_stage: bundle is both a load and a store");

endmodule

// File: sim/mem_stage_model.svh
`ifndef MEM_STAGE_MODEL_SVH
`define MEM_STAGE_MODEL_SVH

// Shadow copy of the data memory and of CP0.
logic [63:0] shadow_mem [MEM_DWORDS];
logic [7:0]  shadow_mask;
logic        shadow_exl;
logic        shadow_ie;
logic [4:0]  shadow_code;
logic [63:0] shadow_epc;

task automatic reset_model();
    for (int i = 0; i < MEM_DWORDS; i++) begin
        shadow_mem[i] = '0;
    end
    shadow_mask = '0;
    shadow_exl  = 1'b0;
    shadow_ie   = 1'b0;
    shadow_code = '0;
    shadow_epc  = '0;
endtask

function automatic logic [63:0] cp0_value(logic [4:0] regnum, logic [2:0] sel, logic [7:0] ints);
    if (sel != 3'd0) return '0;
    case (regnum)
        CP0_STATUS: return {48'b0, shadow_mask, 6'b0, shadow_exl, shadow_ie};
        CP0_CAUSE:  return {48'b0, ints, 1'b0, shadow_code, 2'b0};
        CP0_EPC:    return shadow_epc;
        default:    return '0;
    endcase
endfunction

function automatic logic [63:0] load_value(ex_regs_t ex);
    logic [63:0] dw;
    logic [63:0] b;
    logic [63:0] w;
    dw = shadow_mem[ex.alu_out[10:3]];
    b  = dw >> (8 * ex.alu_out[2:0]);     // Addressed byte at the bottom.
    w  = dw >> (32 * ex.alu_out[2]);      // Addressed half at the bottom.
    case (ex.mem_load_type)
        LOAD_BYTE:   return ex.load_signed ? {{56{b[7]}}, b[7:0]} : {56'b0, b[7:0]};
        LOAD_WORD:   return ex.load_signed ? {{32{w[31]}}, w[31:0]} : {32'b0, w[31:0]};
        LOAD_DOUBLE: return dw;
        default:     return ex.alu_out;
    endcase
endfunction

// Expected mem_regs for a bundle, from the state before the edge.
function automatic mem_regs_t predict(ex_regs_t ex, logic [7:0] ints, logic [63:0] npc,
                                      logic ext, logic [63:0] drd);
    mem_regs_t r;
    r.w_regnum      = ex.w_regnum;
    r.write_enable  = ex.write_enable;
    r.taken_handler = ex.overflow || ex.reserved_inst
                      || ((|(ints & shadow_mask)) && shadow_ie && !shadow_exl);
    if (r.taken_handler) r.epc = npc;
    else if (ex.mtc0 && ex.sel == 3'd0 && ex.w_regnum == CP0_EPC) r.epc = ex.b_data;
    else r.epc = shadow_epc;
    if (ex.linkpc) r.w_data = ex.pc4;
    else if (ex.mfc0) r.w_data = cp0_value(ex.w_regnum, ex.sel, ints);
    else if (ext) r.w_data = drd;
    else r.w_data = load_value(ex);
    return r;
endfunction

// Applies one rising edge to the shadow state.
task automatic commit(ex_regs_t ex, logic ext, mem_regs_t r);
    logic [63:0] dw;
    dw = shadow_mem[ex.alu_out[10:3]];
    if (!ext) begin
        case (ex.mem_store_type)
            STORE_BYTE:   dw[8*ex.alu_out[2:0] +: 8] = ex.b_data[7:0];
            STORE_WORD:   dw[32*ex.alu_out[2] +: 32] = ex.b_data[31:0];
            STORE_DOUBLE: dw = ex.b_data;
            default:      ;
        endcase
    end
    shadow_mem[ex.alu_out[10:3]] = dw;
    shadow_epc = r.epc;
    if (r.taken_handler) begin
        shadow_exl  = 1'b1;
        shadow_code = ex.overflow ? EXC_OV : (ex.reserved_inst ? EXC_RI : EXC_INT);
    end else if (ex.mtc0 && ex.sel == 3'd0 && ex.w_regnum == CP0_STATUS) begin
        shadow_mask = ex.b_data[15:8];
        shadow_exl  = ex.b_data[1];
        shadow_ie   = ex.b_data[0];
    end else if (ex.eret) begin
        shadow_exl = 1'b0;
    end
endtask

`endif

// File: sim/mem_stage_tb.sv
`timescale 1ns/10ps

module mem_stage_tb;
    import mem_stage_pkg::*;

    localparam int N_RAND    = 120;              // Bundles per random test.
    localparam int TOTAL_OPS = 6 * N_RAND + 13;

    logic        clock;
    logic        reset;
    ex_regs_t    ex_regs;
    logic [63:0] inst_addr;
    logic [31:0] inst;
    logic [7:0]  interrupt_sources;
    logic [63:0] next_pc;
    logic        d_valid;
    logic        d_ready;
    logic [63:0] d_rdata;
    mem_regs_t   mem_regs;
    int          passes;
    int          fails;
    int          fails_before;

    `include "mem_stage_model.svh"

    mem_stage DUT (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        #((TOTAL_OPS + 16) * 10 * 2);
        $display("Timeout: the tests did not finish in the expected time");
        $display("*** FAILED ***");
        $finish;
    end

    task automatic compare(input logic [63:0] got, input logic [63:0] want, input string what);
        if (got !== want) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, want);
            fails++;
        end else begin
            passes++;
        end
    endtask

    task automatic report(input string name);
        $display("Test %s finished with %0d mismatches", name, fails - fails_before);
        fails_before = fails;
    endtask

    function automatic ex_regs_t random_bundle(int kind);
        ex_regs_t ex;
        ex              = '0;
        ex.alu_out      = $urandom_range(0, 2047);   // Stays inside the 256 doublewords.
        ex.b_data       = {$urandom, $urandom};
        ex.pc4          = {$urandom, $urandom};
        ex.w_regnum     = $urandom;
        ex.write_enable = $urandom;
        case (kind)
            0: ex.mem_store_type = store_kind_e'($urandom_range(0, 3));
            1: begin
                ex.mem_load_type = load_kind_e'($urandom_range(0, 3));
                ex.load_signed   = $urandom;
            end
            2: ex.linkpc = $urandom;
            default: ;
        endcase
        return ex;
    endfunction

    function automatic ex_regs_t cp0_bundle(logic to_cp0, logic from_cp0, logic ret,
                                            logic [4:0] regnum, logic [2:0] sel,
                                            logic [63:0] data);
        ex_regs_t ex;
        ex          = random_bundle(3);
        ex.mtc0     = to_cp0;
        ex.mfc0     = from_cp0;
        ex.eret     = ret;
        ex.w_regnum = regnum;
        ex.sel      = sel;
        ex.b_data   = data;
        return ex;
    endfunction

    // One bundle: drive at the falling edge, check at the next one.
    task automatic step(input ex_regs_t ex, input logic [1:0] ext);
        mem_regs_t   want;
        logic [63:0] dw;
        ex_regs   = ex;
        d_valid   = ext[0];
        d_ready   = ext[1];
        d_rdata   = {$urandom, $urandom};
        next_pc   = {$urandom, $urandom};
        inst_addr = $urandom_range(0, 2047);
        want = predict(ex, interrupt_sources, next_pc, |ext, d_rdata);
        @(posedge clock);
        commit(ex, |ext, want);
        @(negedge clock);
        dw = shadow_mem[inst_addr[10:3]];
        compare(mem_regs.w_data, want.w_data, "w_data");
        compare(mem_regs.epc, want.epc, "epc");
        compare(mem_regs.w_regnum, want.w_regnum, "w_regnum");
        compare(mem_regs.write_enable, want.write_enable, "write_enable");
        compare(mem_regs.taken_handler, want.taken_handler, "taken_handler");
        compare(inst, inst_addr[2] ? dw[63:32] : dw[31:0], "inst");
    endtask

    initial begin
        ex_regs_t ex;
        int       op;
        void'($urandom(81593));
        reset             = 1'b1;
        ex_regs           = '0;
        inst_addr         = '0;
        interrupt_sources = '0;
        next_pc           = '0;
        d_valid           = 1'b0;
        d_ready           = 1'b0;
        d_rdata           = '0;
        passes            = 0;
        fails             = 0;
        fails_before      = 0;
        reset_model();
        repeat (16) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        repeat (N_RAND) step(random_bundle($urandom_range(0, 1)), 2'b00);
        report("loads and stores");
        repeat (N_RAND) step(random_bundle($urandom_range(2, 3)), 2'b00);
        report("non-memory bundles");

        repeat (N_RAND / 2) begin
            ex = random_bundle(0);
            step(ex, $urandom_range(1, 3));            // Store is dropped.
            ex.mem_store_type = STORE_NONE;
            ex.mem_load_type  = LOAD_DOUBLE;
            step(ex, 2'b00);
        end
        report("external data port");
        repeat (N_RAND) step(random_bundle(0), 2'b00);
        report("instruction port");

        step(cp0_bundle(1, 0, 0, CP0_STATUS, 3'd0, 64'hdead_beef_a5a5_ff05), 2'b00);
        step(cp0_bundle(0, 1, 0, CP0_STATUS, 3'd0, '0), 2'b00);
        compare(mem_regs.w_data, 64'hff01, "status readback");
        step(cp0_bundle(1, 0, 0, CP0_EPC, 3'd0, 64'h1234_5678_9abc_def0), 2'b00);
        step(cp0_bundle(0, 1, 0, CP0_EPC, 3'd0, '0), 2'b00);
        step(cp0_bundle(0, 1, 0, 5'd3, 3'd0, '0), 2'b00);
        step(cp0_bundle(0, 1, 0, CP0_STATUS, 3'd1, '0), 2'b00);
        interrupt_sources = 8'h24;
        step(cp0_bundle(0, 0, 0, 5'd0, 3'd0, '0), 2'b00);
        compare(mem_regs.taken_handler, 1, "interrupt taken");
        step(cp0_bundle(0, 1, 0, CP0_CAUSE, 3'd0, '0), 2'b00);
        compare(mem_regs.taken_handler, 0, "interrupt blocked while EXL set");
        step(cp0_bundle(0, 0, 1, 5'd0, 3'd0, '0), 2'b00);
        step(cp0_bundle(0, 0, 0, 5'd0, 3'd0, '0), 2'b00);
        compare(mem_regs.taken_handler, 1, "interrupt after ERET");
        interrupt_sources = 8'h00;
        step(cp0_bundle(0, 0, 1, 5'd0, 3'd0, '0), 2'b00);
        step(cp0_bundle(0, 1, 0, CP0_STATUS, 3'd0, '0), 2'b00);
        repeat (N_RAND) begin
            interrupt_sources = $urandom;
            op = $urandom_range(0, 3);              // MTC0, MFC0, ERET or none.
            step(cp0_bundle(op == 0, op == 1, op == 2, $urandom_range(11, 15),
                            ($urandom_range(0, 3) == 0) ? 3'd1 : 3'd0,
                            {$urandom, $urandom}), 2'b00);
        end
        report("cp0 and interrupts");

        interrupt_sources = 8'h00;
        step(cp0_bundle(1, 0, 0, CP0_STATUS, 3'd0, '0), 2'b00);   // Interrupts off.
        repeat (N_RAND / 2) begin
            interrupt_sources = $urandom;
            ex                = random_bundle($urandom_range(0, 3));
            ex.overflow       = $urandom;
            ex.reserved_inst  = !ex.overflow || ($urandom_range(0, 1) == 1);
            step(ex, 2'b00);
            compare(mem_regs.taken_handler, 1, "exception taken");
            step(cp0_bundle(0, 1, 0, CP0_CAUSE, 3'd0, '0), 2'b00);
        end
        report("overflow and reserved instruction");

        $display("Summary: %0d checks passed, %0d checks failed", passes, fails);
        if (fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: mem_stage.f
+incdir+sim
hw/mem_stage_pkg.sv
hw/data_mem.sv
hw/load_align.sv
hw/cp0_unit.sv
hw/mem_stage.sv
sim/mem_stage_tb.sv
